// File: source/mem_pkg.sv
package mem_pkg;

    localparam int cl_bits        = 128;
    localparam int bank_lines     = 4096;
    localparam int num_banks      = 2;
    localparam int bank_sel_bit   = 5;       // Even/odd bank select
    localparam int idx_lsb        = 6;
    localparam int idx_msb        = 17;
    localparam int bank_latency   = 6;       // Accept to registered reply
    localparam int req_fifo_depth = 4;       // Also the requester's initial credits
    localparam int rsp_slots      = 2;       // Merger slots per bank
    localparam int out_credits    = 4;       // Consumer buffer size

    localparam logic [1:0] mem_node = 2'd3;  // Source ID on every reply

    localparam int lat_cnt_bits = $clog2(bank_latency);
    localparam int req_ptr_bits = $clog2(req_fifo_depth);
    localparam int req_cnt_bits = $clog2(req_fifo_depth + 1);
    localparam int rsp_ptr_bits = $clog2(rsp_slots);
    localparam int rsp_cnt_bits = $clog2(rsp_slots + 1);
    localparam int out_cnt_bits = $clog2(out_credits + 1);

    typedef enum logic [2:0] {
        NOOP  = 3'd0,
        REPLY = 3'd2,
        RD    = 3'd3,
        WR    = 3'd4
    } mem_op_e;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_ACCESS,
        BANK_RESPOND
    } bank_state_e;

    typedef struct packed {
        logic [31:0]        addr;
        mem_op_e            op;
        logic [1:0]         src;
        logic [1:0]         dest;
        logic [cl_bits-1:0] data;
    } mem_req_t;

    // Same layout as a request, op is always REPLY
    typedef struct packed {
        logic [31:0]        addr;
        mem_op_e            op;
        logic [1:0]         src;
        logic [1:0]         dest;
        logic [cl_bits-1:0] data;
    } mem_rsp_t;

endpackage

// File: source/mem_bank.sv
`timescale 1ns/1ps

module mem_bank import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     busy,
    output logic     rsp_valid,
    output mem_rsp_t rsp
);

    logic [cl_bits-1:0]       lines [bank_lines];
    bank_state_e              state;
    logic [lat_cnt_bits-1:0]  lat_cnt;
    mem_req_t                 req_q;
    logic                     accept;
    logic                     access_done;
    logic [idx_msb-idx_lsb:0] line_idx;

    assign busy        = (state == BANK_ACCESS);
    assign accept      = req_valid && !busy;
    assign access_done = (state == BANK_ACCESS) && (lat_cnt == '0);  // Last access cycle
    assign line_idx    = req_q.addr[idx_msb:idx_lsb];

    // Latency FSM, RESPOND is the reply cycle and can take a new request
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BANK_IDLE;
            lat_cnt   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                BANK_IDLE, BANK_RESPOND: begin
                    if (accept) begin
                        state   <= BANK_ACCESS;
                        lat_cnt <= lat_cnt_bits'(bank_latency - 1);
                    end else begin
                        state <= BANK_IDLE;
                    end
                end
                BANK_ACCESS: begin
                    if (access_done) begin
                        state     <= BANK_RESPOND;
                        rsp_valid <= (req_q.op == RD);  // Writes are silent
                    end else begin
                        lat_cnt <= lat_cnt - lat_cnt_bits'(1);
                    end
                end
                default: begin
                    state <= BANK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (access_done && req_q.op == WR) begin
            lines[line_idx] <= req_q.data;
        end
    end

    always_ff @(posedge clk) begin
        if (access_done && req_q.op == RD) begin
            rsp <= '{
                addr: req_q.addr,
                op:   REPLY,
                src:  mem_node,
                dest: req_q.src,   // Back to the requester
                data: lines[line_idx]
            };
        end
    end

    // Dispatcher must respect busy
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> !busy
    );

    // NOOPs are dropped before they reach a bank
    a_req_op_legal: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> req.op inside {RD, WR}
    );

endmodule

// File: source/bank_dispatch.sv
`timescale 1ns/1ps

module bank_dispatch import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  mem_req_t             req,
    output logic                 req_credit,
    input  logic [num_banks-1:0] bank_busy,
    input  logic [num_banks-1:0] bank_credit,
    output logic [num_banks-1:0] bank_req_valid,
    output mem_req_t             bank_req
);

    mem_req_t                fifo_mem [req_fifo_depth];
    logic [req_ptr_bits-1:0] wr_ptr;
    logic [req_ptr_bits-1:0] rd_ptr;
    logic [req_cnt_bits-1:0] fifo_cnt;
    logic [rsp_cnt_bits-1:0] rsp_cnt [num_banks];  // Free merger slots per bank
    logic [num_banks-1:0]    rd_issue;
    logic                    head_bank;
    logic                    head_ready;
    logic                    pop;

    assign bank_req  = fifo_mem[rd_ptr];
    assign head_bank = bank_req.addr[bank_sel_bit];

    always_comb begin
        case (bank_req.op)
            NOOP:    head_ready = 1'b1;  // Dropped here
            RD:      head_ready = !bank_busy[head_bank] && (rsp_cnt[head_bank] != '0);
            default: head_ready = !bank_busy[head_bank];
        endcase
    end

    assign pop = (fifo_cnt != '0) && head_ready;

    always_comb begin
        bank_req_valid = '0;
        if (pop && bank_req.op != NOOP) begin
            bank_req_valid[head_bank] = 1'b1;
        end
    end

    assign rd_issue = bank_req_valid & {num_banks{bank_req.op == RD}};

    always_ff @(posedge clk) begin
        if (req_valid) begin
            fifo_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
            req_credit <= 1'b0;
            for (int b = 0; b < num_banks; b++) begin
                rsp_cnt[b] <= rsp_cnt_bits'(rsp_slots);
            end
        end else begin
            req_credit <= pop;  // Entry freed, hand the credit back
            if (req_valid) begin
                wr_ptr <= wr_ptr + req_ptr_bits'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + req_ptr_bits'(1);
            end
            if (req_valid && !pop) begin
                fifo_cnt <= fifo_cnt + req_cnt_bits'(1);
            end else if (pop && !req_valid) begin
                fifo_cnt <= fifo_cnt - req_cnt_bits'(1);
            end
            for (int b = 0; b < num_banks; b++) begin
                if (rd_issue[b] && !bank_credit[b]) begin
                    rsp_cnt[b] <= rsp_cnt[b] - rsp_cnt_bits'(1);
                end else if (bank_credit[b] && !rd_issue[b]) begin
                    rsp_cnt[b] <= rsp_cnt[b] + rsp_cnt_bits'(1);
                end
            end
        end
    end

    // Requester credits must keep the FIFO from overflowing
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> fifo_cnt != req_cnt_bits'(req_fifo_depth)
    );

    for (genvar gb = 0; gb < num_banks; gb++) begin : g_cnt_chk
        a_rsp_cnt_max: assert property (
            @(posedge clk) disable iff (rst)
            rsp_cnt[gb] <= rsp_slots
        );
    end

endmodule

// File: source/reply_merge.sv
`timescale 1ns/1ps

module reply_merge import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic     [num_banks-1:0] bank_rsp_valid,
    input  mem_rsp_t [num_banks-1:0] bank_rsp,
    output logic     [num_banks-1:0] bank_credit,
    output logic                     rsp_valid,
    output mem_rsp_t                 rsp,
    input  logic                     rsp_credit
);

    mem_rsp_t                slot_mem [num_banks][rsp_slots];
    logic [rsp_ptr_bits-1:0] wr_ptr [num_banks];
    logic [rsp_ptr_bits-1:0] rd_ptr [num_banks];
    logic [rsp_cnt_bits-1:0] slot_cnt [num_banks];
    logic [out_cnt_bits-1:0] out_cnt;
    logic [num_banks-1:0]    slot_full_any;
    logic                    rr_ptr;  // Bank preferred on a tie
    logic                    sel;
    logic                    send;
    logic [num_banks-1:0]    pop;

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            slot_full_any[b] = (slot_cnt[b] != '0);
        end
    end

    assign send = (out_cnt != '0) && (slot_full_any != '0);
    assign sel  = (&slot_full_any) ? rr_ptr : slot_full_any[1];

    always_comb begin
        pop = '0;
        if (send) begin
            pop[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (bank_rsp_valid[b]) begin
                slot_mem[b][wr_ptr[b]] <= bank_rsp[b];
            end
        end
        if (send) begin
            rsp <= slot_mem[sel][rd_ptr[sel]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < num_banks; b++) begin
                wr_ptr[b]   <= '0;
                rd_ptr[b]   <= '0;
                slot_cnt[b] <= '0;
            end
            out_cnt     <= out_cnt_bits'(out_credits);
            rr_ptr      <= 1'b0;
            rsp_valid   <= 1'b0;
            bank_credit <= '0;
        end else begin
            rsp_valid   <= send;
            bank_credit <= pop;  // Slot freed for the dispatcher
            if (send) begin
                rr_ptr <= !sel;
            end
            for (int b = 0; b < num_banks; b++) begin
                if (bank_rsp_valid[b]) begin
                    wr_ptr[b] <= wr_ptr[b] + rsp_ptr_bits'(1);
                end
                if (pop[b]) begin
                    rd_ptr[b] <= rd_ptr[b] + rsp_ptr_bits'(1);
                end
                if (bank_rsp_valid[b] && !pop[b]) begin
                    slot_cnt[b] <= slot_cnt[b] + rsp_cnt_bits'(1);
                end else if (pop[b] && !bank_rsp_valid[b]) begin
                    slot_cnt[b] <= slot_cnt[b] - rsp_cnt_bits'(1);
                end
            end
            if (send && !rsp_credit) begin
                out_cnt <= out_cnt - out_cnt_bits'(1);
            end else if (rsp_credit && !send) begin
                out_cnt <= out_cnt + out_cnt_bits'(1);
            end
        end
    end

    // Dispatcher reply credits guarantee a free slot
    for (genvar gb = 0; gb < num_banks; gb++) begin : g_slot_chk
        a_no_slot_overflow: assert property (
            @(posedge clk) disable iff (rst)
            bank_rsp_valid[gb] |-> slot_cnt[gb] < rsp_slots
        );
    end

    // Consumer never returns more than it was given
    a_out_cnt_max: assert property (
        @(posedge clk) disable iff (rst)
        out_cnt <= out_credits
    );

endmodule

// File: source/interleaved_memory.sv
`timescale 1ns/1ps

module interleaved_memory import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     req_credit,
    output logic     rsp_valid,
    output mem_rsp_t rsp,
    input  logic     rsp_credit
);

    logic     [num_banks-1:0] bank_req_valid;
    mem_req_t                 bank_req;        // Shared by both banks
    logic     [num_banks-1:0] bank_busy;
    logic     [num_banks-1:0] bank_rsp_valid;
    mem_rsp_t [num_banks-1:0] bank_rsp;
    logic     [num_banks-1:0] bank_credit;

    bank_dispatch u_dispatch (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .bank_busy      (bank_busy),
        .bank_credit    (bank_credit),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req)
    );

    mem_bank bank_even (
        .clk       (clk),
        .rst       (rst),
        .req_valid (bank_req_valid[0]),
        .req       (bank_req),
        .busy      (bank_busy[0]),
        .rsp_valid (bank_rsp_valid[0]),
        .rsp       (bank_rsp[0])
    );

    mem_bank bank_odd (
        .clk       (clk),
        .rst       (rst),
        .req_valid (bank_req_valid[1]),
        .req       (bank_req),
        .busy      (bank_busy[1]),
        .rsp_valid (bank_rsp_valid[1]),
        .rsp       (bank_rsp[1])
    );

    reply_merge u_merge (
        .clk            (clk),
        .rst            (rst),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_credit    (bank_credit),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_credit     (rsp_credit)
    );

endmodule

// File: dv/tb_interleaved_memory.sv
`timescale 1ns/1ps

module tb_interleaved_memory import mem_pkg::*; ();

    localparam int timeout_cycles = 3000;  // Roughly four times the random mix
    localparam int drain_cycles   = 2 * req_fifo_depth * (bank_latency + 2);  // Full FIFO to one bank

    logic     clk = 1'b0;
    logic     rst;
    logic     req_valid;
    mem_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    mem_rsp_t rsp;
    logic     rsp_credit = 1'b0;

    integer             seed;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    int                 credits = req_fifo_depth;  // Requester view of FIFO space
    int                 min_credits = req_fifo_depth;
    int                 credit_pulses = 0;
    int                 held = 0;                  // Replies taken whose credit is still held
    int                 rsp_count = 0;
    bit                 consumer_on = 1'b1;
    logic [1:0]         src_seq = 2'd0;
    logic [cl_bits-1:0] ref_mem [logic [31:0]];
    mem_rsp_t           outstanding [$];           // Expected replies in issue order

    always #2 clk = ~clk;

    interleaved_memory uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    task automatic check_value(input string name, input logic [cl_bits-1:0] exp,
                               input logic [cl_bits-1:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [cl_bits-1:0] random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Sends one beat at a falling edge once a credit is held
    task automatic send_req(input mem_op_e op, input logic [31:0] addr,
                            input logic [cl_bits-1:0] data);
        mem_rsp_t exp;
        while (credits == 0) begin
            req_valid = 1'b0;
            @(negedge clk);
        end
        req_valid = 1'b1;
        req.addr  = addr;
        req.op    = op;
        req.src   = src_seq;
        req.dest  = mem_node;
        req.data  = (op == WR) ? data : '0;
        credits--;
        if (credits < min_credits) begin
            min_credits = credits;
        end
        if (op == WR) begin
            ref_mem[addr] = data;
        end else if (op == RD) begin
            exp.addr = addr;
            exp.op   = REPLY;
            exp.src  = mem_node;
            exp.dest = src_seq;
            exp.data = ref_mem[addr];  // Value after all earlier writes
            outstanding.push_back(exp);
        end
        src_seq++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Oldest outstanding read of the reply's bank must match
    task automatic take_reply();
        int       idx;
        logic     bank;
        mem_rsp_t exp;
        idx  = -1;
        bank = rsp.addr[bank_sel_bit];
        rsp_count++;
        held++;
        assert (held <= out_credits) else begin
            $display("Reply beat at %0t arrived without an output credit", $time);
            errors++;
        end
        for (int i = 0; i < outstanding.size(); i++) begin
            if (idx < 0 && outstanding[i].addr[bank_sel_bit] == bank) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            $display("Reply for address %0h at %0t matches no outstanding read", rsp.addr, $time);
            errors++;
        end
        if (idx >= 0) begin
            exp = outstanding[idx];
            outstanding.delete(idx);
            check_value("rsp.addr", exp.addr, rsp.addr);
            check_value("rsp.op", exp.op, rsp.op);
            check_value("rsp.src", exp.src, rsp.src);
            check_value("rsp.dest", exp.dest, rsp.dest);
            check_value("rsp.data", exp.data, rsp.data);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && rsp_valid) begin
            take_reply();
        end
        if (consumer_on && held > 0) begin
            rsp_credit = 1'b1;
            held--;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst && req_credit) begin
            credits++;
            credit_pulses++;
            assert (credits <= req_fifo_depth) else begin
                $display("More request credits returned than sent at %0t", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, %0d reads still outstanding",
                     cycles, outstanding.size());
            $display("Summary: %0d checks, %0d errors", checks, errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Waits for every read to be answered, then for the FIFO to drain
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        while (outstanding.size() != 0 || held != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        while (credits != req_fifo_depth && waited < drain_cycles) begin
            @(negedge clk);
            waited++;
        end
        check_value("req credits", req_fifo_depth, credits);
    endtask

    task automatic write_read_each_bank();
        send_req(WR, 32'h0000_0040, random_line());  // Even bank
        send_req(WR, 32'h0000_0060, random_line());  // Odd bank
        send_req(RD, 32'h0000_0040, '0);
        send_req(RD, 32'h0000_0060, '0);
        wait_idle();
        check_value("reply count", 2, rsp_count);
    endtask

    task automatic no_reply_ops();
        int rsp_before;
        int pulses_before;
        rsp_before    = rsp_count;
        pulses_before = credit_pulses;
        for (int i = 0; i < 10; i++) begin
            if (i % 3 == 1) begin
                send_req(NOOP, 32'h0000_2000 + i * 32, random_line());
            end else begin
                send_req(WR, 32'h0000_2000 + i * 32, random_line());
            end
        end
        send_req(RD, 32'h0000_2000, '0);
        wait_idle();
        check_value("reply count", 1, rsp_count - rsp_before);
        check_value("req_credit pulses", 11, credit_pulses - pulses_before);
    endtask

    task automatic interleaved_traffic();
        int rsp_before;
        for (int i = 0; i < 16; i++) begin
            send_req(WR, 32'h0000_1000 + i * 32, random_line());  // Bit 5 alternates
        end
        rsp_before = rsp_count;
        for (int i = 0; i < 16; i++) begin
            send_req(RD, 32'h0000_1000 + i * 32, '0);
        end
        wait_idle();
        check_value("reply count", 16, rsp_count - rsp_before);
    endtask

    task automatic output_backpressure();
        int rsp_before;
        rsp_before  = rsp_count;
        consumer_on = 1'b0;
        for (int i = 0; i < 8; i++) begin
            send_req(RD, 32'h0000_1000 + i * 32, '0);
        end
        while (held < out_credits) begin
            @(posedge clk);
        end
        repeat (2 * bank_latency) @(posedge clk);  // No beat may slip past the stall
        check_value("stalled reply count", out_credits, rsp_count - rsp_before);
        consumer_on = 1'b1;
        wait_idle();
        check_value("reply count", 8, rsp_count - rsp_before);
    endtask

    // Same-bank writes back up the FIFO until the driver runs dry
    task automatic input_credit_limit();
        min_credits = req_fifo_depth;
        for (int i = 0; i < 10; i++) begin
            send_req(WR, 32'h0000_4000 + i * 64, random_line());
        end
        check_value("min req credits", 0, min_credits);
        wait_idle();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        for (int i = 0; i < 200; i++) begin
            r    = $random(seed);
            addr = 32'h0000_8000 + {r[4:0], 5'b0};
            if (r[9:8] == 2'd0) begin
                send_req(NOOP, addr, '0);
            end else if (r[9:8] == 2'd1 || !ref_mem.exists(addr)) begin
                send_req(WR, addr, random_line());
            end else begin
                send_req(RD, addr, '0);
            end
        end
        wait_idle();
    endtask

    initial begin
        seed      = 32'h58ba_06d6;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        write_read_each_bank();
        no_reply_ops();
        interleaved_traffic();
        output_backpressure();
        input_credit_limit();
        random_mix();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: interleaved_memory.f
source/mem_pkg.sv
source/mem_bank.sv
source/bank_dispatch.sv
source/reply_merge.sv
source/interleaved_memory.sv
dv/tb_interleaved_memory.sv
